//--- vlog.f
design/ram_pkg.sv
design/ram_dual_if.sv
design/ram_dual.sv
design/ram_addr_gen.sv
design/ram_cmd_ctrl.sv
design/ram_engine_top.sv
testbench/ram_engine_props.sv
testbench/tb_ram_engine.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log for the pass line.
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -j 0 \
  --top-module tb_ram_engine -f vlog.f -o tb_ram_engine \
  && ./obj_dir/tb_ram_engine 2>&1 | tee sim.log \
  && grep -qx "PASS: all tests" sim.log \
  && echo "Simulation passed." \
  || { echo "Simulation failed."; exit 1; }

//--- testbench/tb_ram_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ram_engine;

  logic                       i_ram;
  logic                       i_rst_n;
  logic                       i_cmd_valid;
  logic [1:0]                 i_cmd_op;
  logic [ram_pkg::ADDR_W-1:0] i_cmd_addr;
  logic [ram_pkg::ADDR_W-1:0] i_cmd_src;
  logic [ram_pkg::LEN_W-1:0]  i_cmd_len;
  logic [ram_pkg::DATA_W-1:0] i_cmd_data;
  logic                       o_busy;
  logic                       o_done;
  logic                       o_err;
  logic                       o_rd_valid;
  logic [ram_pkg::DATA_W-1:0] o_rd_data;

  logic [ram_pkg::DATA_W-1:0] shadow [ram_pkg::DEPTH]; // Expected memory contents.
  logic [31:0]                lfsr_q;

  ram_engine_top u_ram_engine_top (
    .i_ram       (i_ram),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd_op    (i_cmd_op),
    .i_cmd_addr  (i_cmd_addr),
    .i_cmd_src   (i_cmd_src),
    .i_cmd_len   (i_cmd_len),
    .i_cmd_data  (i_cmd_data),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_err       (o_err),
    .o_rd_valid  (o_rd_valid),
    .o_rd_data   (o_rd_data)
  );

  initial begin
    i_ram = 1'b0;
    forever #20 i_ram = ~i_ram;
  end

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
    if (actual !== expected) begin
      $display("error: time %0t: %s: got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
      abort_run();
    end
  endtask

  // One-cycle strobe with the fields held alongside.
  task automatic send_cmd(input ram_pkg::ram_op_e op, input int addr, input int src,
                          input int len, input logic [ram_pkg::DATA_W-1:0] data);
    @(negedge i_ram);
    expect_equal(32'(o_busy), 32'd0, "o_busy before a new command");
    i_cmd_valid = 1'b1;
    i_cmd_op    = op;
    i_cmd_addr  = 6'(addr);
    i_cmd_src   = 6'(src);
    i_cmd_len   = 7'(len);
    i_cmd_data  = data;
    @(negedge i_ram);
    i_cmd_valid = 1'b0;
  endtask

  task automatic wait_end(input logic expect_err, input string what);
    int cycles;
    cycles = 0;
    while (!(o_done || o_err)) begin
      if (cycles > 300) begin
        $display("timeout: %s did not finish within 300 cycles", what);
        abort_run();
      end
      @(negedge i_ram);
      cycles++;
    end
    expect_equal(32'(o_err), 32'(expect_err), $sformatf("%s o_err", what));
    expect_equal(32'(o_done), 32'(!expect_err), $sformatf("%s o_done", what));
    @(negedge i_ram);
    expect_equal(32'(o_done | o_err), 32'd0, $sformatf("%s end pulse width", what));
    expect_equal(32'(o_busy), 32'd0, $sformatf("%s o_busy after end", what));
  endtask

  task automatic write_word(input int addr, input logic [ram_pkg::DATA_W-1:0] data);
    send_cmd(ram_pkg::OP_WRITE, addr, 0, 1, data);
    wait_end(1'b0, "WRITE");
    shadow[addr] = data;
  endtask

  // Words must arrive back to back and o_done comes with the last one.
  task automatic read_check(input int addr, input int len, input string what);
    int got;
    int cycles;
    got = 0;
    cycles = 0;
    send_cmd(ram_pkg::OP_READ, addr, 0, len, '0);
    while (got < len) begin
      expect_equal(32'(o_err), 32'd0, $sformatf("%s o_err", what));
      if (o_rd_valid) begin
        expect_equal(32'(o_rd_data), 32'(shadow[addr + got]),
                     $sformatf("%s word at 0x%0h", what, addr + got));
        expect_equal(32'(o_done), (got == len - 1) ? 32'd1 : 32'd0,
                     $sformatf("%s o_done at word %0d", what, got));
        got++;
      end else if (got > 0) begin
        expect_equal(32'(o_rd_valid), 32'd1, $sformatf("%s back-to-back words", what));
      end
      if (got < len) begin
        if (cycles > 300) begin
          $display("timeout: %s got only %0d of %0d words", what, got, len);
          abort_run();
        end
        @(negedge i_ram);
        cycles++;
      end
    end
    @(negedge i_ram);
    expect_equal(32'(o_rd_valid | o_done), 32'd0, $sformatf("%s extra pulse", what));
    expect_equal(32'(o_busy), 32'd0, $sformatf("%s o_busy after end", what));
  endtask

  task automatic reject_cmd(input ram_pkg::ram_op_e op, input int addr, input int src,
                            input int len, input string what);
    send_cmd(op, addr, src, len, 16'hdead);
    wait_end(1'b1, what);
  endtask

  task automatic write_all_then_read();
    for (int a = 0; a < ram_pkg::DEPTH; a++) begin
      write_word(a, 16'(rand_bits(16)));
    end
    read_check(0, ram_pkg::DEPTH, "full READ after WRITEs");
  endtask

  task automatic fill_window();
    int start;
    int len;
    int lo;
    int hi;
    logic [ram_pkg::DATA_W-1:0] val;
    for (int n = 0; n < 3; n++) begin
      start = int'(rand_bits(6));
      len   = 1 + int'(rand_bits(8)) % (ram_pkg::DEPTH - start);
      val   = 16'(rand_bits(16));
      send_cmd(ram_pkg::OP_FILL, start, 0, len, val);
      wait_end(1'b0, "FILL");
      for (int i = start; i < start + len; i++) begin
        shadow[i] = val;
      end
      lo = (start >= 2) ? start - 2 : 0;  // Neighbors must stay untouched.
      hi = (start + len + 2 <= ram_pkg::DEPTH) ? start + len + 2 : ram_pkg::DEPTH;
      read_check(lo, hi - lo, "window around FILL");
    end
  endtask

  task automatic copy_range();
    int len;
    int lower;
    int upper;
    int src;
    int dst;
    len   = 1 + int'(rand_bits(4));
    lower = int'(rand_bits(8)) % (33 - len);
    upper = 32 + int'(rand_bits(8)) % (33 - len); // Halves never overlap.
    if (rand_bits(1) != 0) begin
      src = lower;
      dst = upper;
    end else begin
      src = upper;
      dst = lower;
    end
    send_cmd(ram_pkg::OP_COPY, dst, src, len, '0);
    wait_end(1'b0, "COPY");
    for (int i = 0; i < len; i++) begin
      shadow[dst + i] = shadow[src + i];
    end
    read_check(dst, len, "COPY destination");
    read_check(src, len, "COPY source");
  endtask

  task automatic range_errors();
    reject_cmd(ram_pkg::OP_READ, 5, 0, 0, "READ of length 0");
    reject_cmd(ram_pkg::OP_READ, 60, 0, 5, "READ past the end");
    reject_cmd(ram_pkg::OP_FILL, 0, 0, 0, "FILL of length 0");
    reject_cmd(ram_pkg::OP_FILL, 40, 0, 30, "FILL past the end");
    reject_cmd(ram_pkg::OP_FILL, 0, 0, 127, "FILL longer than memory");
    reject_cmd(ram_pkg::OP_COPY, 0, 50, 20, "COPY source past the end");
    reject_cmd(ram_pkg::OP_COPY, 63, 0, 2, "COPY destination past the end");
    reject_cmd(ram_pkg::OP_COPY, 10, 20, 0, "COPY of length 0");
    read_check(0, ram_pkg::DEPTH, "memory after rejected commands");
  endtask

  // A WRITE strobed in the middle of a FILL must be dropped.
  task automatic busy_strobe_dropped();
    int done_cnt;
    int cycles;
    logic [ram_pkg::DATA_W-1:0] val;
    done_cnt = 0;
    cycles   = 0;
    val      = 16'(rand_bits(16));
    send_cmd(ram_pkg::OP_FILL, 0, 0, 40, val);
    while (o_busy || cycles < 8) begin
      if (o_done) begin
        done_cnt++;
      end
      expect_equal(32'(o_err), 32'd0, "o_err during FILL");
      if (cycles > 300) begin
        $display("timeout: FILL with a stray strobe did not finish");
        abort_run();
      end
      @(negedge i_ram);
      cycles++;
      if (cycles == 4) begin
        i_cmd_valid = 1'b1;
        i_cmd_op    = ram_pkg::OP_WRITE;
        i_cmd_addr  = 6'd50;
        i_cmd_data  = ~shadow[50];
      end else if (cycles == 5) begin
        i_cmd_valid = 1'b0;
      end
    end
    for (int k = 0; k < 4; k++) begin
      @(negedge i_ram);
      expect_equal(32'(o_busy | o_done), 32'd0, "activity after FILL");
    end
    expect_equal(32'(done_cnt), 32'd1, "o_done count for FILL");
    for (int i = 0; i < 40; i++) begin
      shadow[i] = val;
    end
    read_check(0, ram_pkg::DEPTH, "memory after dropped WRITE");
  endtask

  initial begin
    lfsr_q      = 32'hc1e0_7ed0;
    i_rst_n     = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd_op    = '0;
    i_cmd_addr  = '0;
    i_cmd_src   = '0;
    i_cmd_len   = '0;
    i_cmd_data  = '0;
    repeat (4) @(posedge i_ram);
    @(negedge i_ram);
    expect_equal(32'(o_busy | o_done | o_err | o_rd_valid), 32'd0, "outputs in reset");
    i_rst_n = 1'b1;
    write_all_then_read();
    fill_window();
    copy_range();
    range_errors();
    busy_strobe_dropped();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/ram_engine_props.sv
`timescale 1ns/1ps
`default_nettype none

module ram_engine_props (
  input logic                       i_ram,
  input logic                       i_rst_n,
  input logic                       i_wren,
  input logic [ram_pkg::ADDR_W-1:0] i_waddr,
  input logic                       i_rden,
  input logic [ram_pkg::ADDR_W-1:0] i_raddr,
  input logic                       i_rd_valid,
  input logic                       i_busy,
  input logic                       i_done,
  input logic                       i_err,
  input logic                       i_out_valid
);

  // A stream that reaches the last word must stop there.
  a_waddr_range: assert property (@(posedge i_ram) disable iff (!i_rst_n)
    (i_wren && (int'(i_waddr) == ram_pkg::DEPTH - 1)) |=> !i_wren)
    else $error("write stream runs past the last word");

  a_raddr_range: assert property (@(posedge i_ram) disable iff (!i_rst_n)
    (i_rden && (int'(i_raddr) == ram_pkg::DEPTH - 1)) |=> !i_rden)
    else $error("read stream runs past the last word");

  // Read data valid exactly one cycle after each read.
  a_rd_valid_set: assert property (@(posedge i_ram) disable iff (!i_rst_n)
    i_rden |=> i_rd_valid)
    else $error("rd_valid missing after rden");

  a_rd_valid_clr: assert property (@(posedge i_ram) disable iff (!i_rst_n)
    !i_rden |=> !i_rd_valid)
    else $error("rd_valid without a preceding rden");

  a_done_err: assert property (@(posedge i_ram) disable iff (!i_rst_n)
    !(i_done && i_err))
    else $error("o_done and o_err high together");

  a_reset_quiet: assert property (@(posedge i_ram)
    !i_rst_n |-> (!i_busy && !i_done && !i_out_valid))
    else $error("strobes active during reset");

endmodule

bind ram_engine_top ram_engine_props u_ram_engine_props (
  .i_ram       (i_ram),
  .i_rst_n     (i_rst_n),
  .i_wren      (u_ram_if.wren),
  .i_waddr     (u_ram_if.waddr),
  .i_rden      (u_ram_if.rden),
  .i_raddr     (u_ram_if.raddr),
  .i_rd_valid  (u_ram_if.rd_valid),
  .i_busy      (o_busy),
  .i_done      (o_done),
  .i_err       (o_err),
  .i_out_valid (o_rd_valid)
);

`default_nettype wire

//--- design/ram_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module ram_engine_top (
  input  logic                       i_ram,
  input  logic                       i_rst_n,
  input  logic                       i_cmd_valid,
  input  logic [1:0]                 i_cmd_op,
  input  logic [ram_pkg::ADDR_W-1:0] i_cmd_addr,
  input  logic [ram_pkg::ADDR_W-1:0] i_cmd_src,
  input  logic [ram_pkg::LEN_W-1:0]  i_cmd_len,
  input  logic [ram_pkg::DATA_W-1:0] i_cmd_data,
  output logic                       o_busy,
  output logic                       o_done,
  output logic                       o_err,
  output logic                       o_rd_valid,
  output logic [ram_pkg::DATA_W-1:0] o_rd_data
);

  logic                       load;
  logic [ram_pkg::ADDR_W-1:0] rd_base;
  logic [ram_pkg::ADDR_W-1:0] wr_base;

  ram_dual_if u_ram_if (
    .ram   (i_ram),
    .rst_n (i_rst_n)
  );

  ram_cmd_ctrl u_ram_cmd_ctrl (
    .i_ram       (i_ram),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd_op    (ram_pkg::ram_op_e'(i_cmd_op)),
    .i_cmd_addr  (i_cmd_addr),
    .i_cmd_src   (i_cmd_src),
    .i_cmd_len   (i_cmd_len),
    .i_cmd_data  (i_cmd_data),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .o_err       (o_err),
    .o_rd_valid  (o_rd_valid),
    .o_rd_data   (o_rd_data),
    .o_load      (load),
    .o_rd_base   (rd_base),
    .o_wr_base   (wr_base),
    .ram         (u_ram_if.ctrl_mp)
  );

  ram_addr_gen u_ram_addr_gen (
    .i_ram     (i_ram),
    .i_rst_n   (i_rst_n),
    .i_load    (load),
    .i_rd_base (rd_base),
    .i_wr_base (wr_base),
    .ram       (u_ram_if.agen_mp)
  );

  ram_dual #(
    .NUM_WORD   (ram_pkg::DEPTH),
    .DATA_WIDTH (ram_pkg::DATA_W)
  ) u_ram_dual (
    .ram (u_ram_if.mem_mp)
  );

endmodule

`default_nettype wire

//--- design/ram_cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ram_cmd_ctrl (
  input  logic                       i_ram,
  input  logic                       i_rst_n,
  input  logic                       i_cmd_valid,
  input  ram_pkg::ram_op_e           i_cmd_op,
  input  logic [ram_pkg::ADDR_W-1:0] i_cmd_addr,
  input  logic [ram_pkg::ADDR_W-1:0] i_cmd_src,
  input  logic [ram_pkg::LEN_W-1:0]  i_cmd_len,
  input  logic [ram_pkg::DATA_W-1:0] i_cmd_data,
  output logic                       o_busy,
  output logic                       o_done,
  output logic                       o_err,
  output logic                       o_rd_valid,
  output logic [ram_pkg::DATA_W-1:0] o_rd_data,
  output logic                       o_load,
  output logic [ram_pkg::ADDR_W-1:0] o_rd_base,
  output logic [ram_pkg::ADDR_W-1:0] o_wr_base,
  ram_dual_if.ctrl_mp                ram
);

  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    RUN_WRITE,
    RUN_READ,
    RUN_FILL,
    RUN_COPY,
    FINISH
  } state_e;

  state_e                     state;
  state_e                     state_nxt;
  ram_pkg::ram_op_e           op_q;
  logic [ram_pkg::ADDR_W-1:0] addr_q;
  logic [ram_pkg::ADDR_W-1:0] src_q;
  logic [ram_pkg::LEN_W-1:0]  len_q;
  logic [ram_pkg::DATA_W-1:0] data_q;
  logic [ram_pkg::LEN_W-1:0]  rd_cnt;
  logic [ram_pkg::LEN_W-1:0]  wr_cnt;
  logic [ram_pkg::LEN_W-1:0]  eff_len;
  logic [ram_pkg::LEN_W:0]    dst_end;
  logic [ram_pkg::LEN_W:0]    src_end;
  logic                       range_err;
  logic                       accept;
  logic                       rd_last;
  logic                       wr_last;
  logic                       rden;
  logic                       wren;

  assign accept = (state == IDLE) && i_cmd_valid; // Strobes while busy are dropped.

  always_ff @(posedge i_ram) begin
    if (accept) begin
      op_q   <= i_cmd_op;
      addr_q <= i_cmd_addr;
      src_q  <= i_cmd_src;
      len_q  <= i_cmd_len;
      data_q <= i_cmd_data;
    end
  end

  // WRITE always covers one word.
  assign eff_len = (op_q == ram_pkg::OP_WRITE) ? (ram_pkg::LEN_W)'(1) : len_q;

  assign dst_end = {1'b0, eff_len} + (ram_pkg::LEN_W+1)'(addr_q);
  assign src_end = {1'b0, eff_len} + (ram_pkg::LEN_W+1)'(src_q);

  assign range_err = (eff_len == '0) ||
                     (dst_end > (ram_pkg::LEN_W+1)'(ram_pkg::DEPTH)) ||
                     ((op_q == ram_pkg::OP_COPY) &&
                      (src_end > (ram_pkg::LEN_W+1)'(ram_pkg::DEPTH)));

  assign rd_last = (rd_cnt == len_q - 1'b1);
  assign wr_last = (wr_cnt == len_q - 1'b1);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (i_cmd_valid) begin
          state_nxt = CHECK;
        end
      end
      CHECK: begin
        if (range_err) begin
          state_nxt = IDLE;
        end else begin
          case (op_q)
            ram_pkg::OP_WRITE: state_nxt = RUN_WRITE;
            ram_pkg::OP_READ:  state_nxt = RUN_READ;
            ram_pkg::OP_FILL:  state_nxt = RUN_FILL;
            default:           state_nxt = RUN_COPY;
          endcase
        end
      end
      RUN_WRITE: state_nxt = FINISH;
      RUN_READ: begin
        if (rd_last) begin
          state_nxt = FINISH; // Last word returns in FINISH.
        end
      end
      RUN_FILL: begin
        if (wr_last) begin
          state_nxt = FINISH;
        end
      end
      RUN_COPY: begin
        if (ram.rd_valid && wr_last) begin
          state_nxt = FINISH;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_ram or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Issued reads and completed writes.
  always_ff @(posedge i_ram or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else if (state == CHECK) begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      if (rden) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
      if (wren) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  assign rden = (state == RUN_READ) || ((state == RUN_COPY) && (rd_cnt != len_q));
  assign wren = (state == RUN_WRITE) || (state == RUN_FILL) ||
                ((state == RUN_COPY) && ram.rd_valid);

  assign ram.rden  = rden;
  assign ram.wren  = wren;
  assign ram.wdata = (state == RUN_COPY) ? ram.rdata : data_q; // COPY forwards read data.

  // Address generator bases load once the range passes.
  assign o_load    = (state == CHECK) && !range_err;
  assign o_rd_base = (op_q == ram_pkg::OP_COPY) ? src_q : addr_q;
  assign o_wr_base = addr_q;

  assign o_busy = (state != IDLE);
  assign o_done = (state == FINISH);
  assign o_err  = (state == CHECK) && range_err;

  assign o_rd_valid = ram.rd_valid && (op_q == ram_pkg::OP_READ) &&
                      ((state == RUN_READ) || (state == FINISH));
  assign o_rd_data  = o_rd_valid ? ram.rdata : '0;

endmodule

`default_nettype wire

//--- design/ram_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ram_addr_gen (
  input  logic                       i_ram,
  input  logic                       i_rst_n,
  input  logic                       i_load,
  input  logic [ram_pkg::ADDR_W-1:0] i_rd_base,
  input  logic [ram_pkg::ADDR_W-1:0] i_wr_base,
  ram_dual_if.agen_mp                ram
);

  logic [ram_pkg::ADDR_W-1:0] rd_addr;
  logic [ram_pkg::ADDR_W-1:0] wr_addr;

  // Read stream.
  always_ff @(posedge i_ram or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_addr <= '0;
    end else if (i_load) begin
      rd_addr <= i_rd_base;
    end else if (ram.rden) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // Write stream lags the reads during COPY.
  always_ff @(posedge i_ram or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_addr <= '0;
    end else if (i_load) begin
      wr_addr <= i_wr_base;
    end else if (ram.wren) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  assign ram.raddr = rd_addr;
  assign ram.waddr = wr_addr;

endmodule

`default_nettype wire

//--- design/ram_dual.sv
`timescale 1ns/1ps
`default_nettype none

module ram_dual #(
  parameter int NUM_WORD   = ram_pkg::DEPTH,
  parameter int DATA_WIDTH = ram_pkg::DATA_W
) (
  ram_dual_if.mem_mp ram
);

  logic [DATA_WIDTH-1:0] mem [NUM_WORD];
  logic [DATA_WIDTH-1:0] q;
  logic                  rd_valid_q;

  // Write port.
  always_ff @(posedge ram.ram) begin
    if (ram.wren) begin
      mem[ram.waddr] <= ram.wdata;
    end
  end

  // Registered read of one word per rden.
  always_ff @(posedge ram.ram) begin
    if (ram.rden) begin
      q <= mem[ram.raddr];
    end
  end

  // Read enable delayed by one cycle qualifies q.
  always_ff @(posedge ram.ram or negedge ram.rst_n) begin
    if (!ram.rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= ram.rden;
    end
  end

  assign ram.rd_valid = rd_valid_q;
  assign ram.rdata    = rd_valid_q ? q : '0; // Quiet bus between reads.

endmodule

`default_nettype wire

//--- design/ram_dual_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_dual_if (
  input logic ram,
  input logic rst_n
);

  logic                       wren;
  logic [ram_pkg::ADDR_W-1:0] waddr;
  logic [ram_pkg::DATA_W-1:0] wdata;
  logic                       rden;
  logic [ram_pkg::ADDR_W-1:0] raddr;
  logic [ram_pkg::DATA_W-1:0] rdata;  // Zero unless rd_valid.
  logic                       rd_valid;

  modport ctrl_mp (
    output wren,
    output wdata,
    output rden,
    input  rdata,
    input  rd_valid
  );

  // Counters advance on each access.
  modport agen_mp (
    output waddr,
    output raddr,
    input  wren,
    input  rden
  );

  modport mem_mp (
    input  ram,
    input  rst_n,
    input  wren,
    input  waddr,
    input  wdata,
    input  rden,
    input  raddr,
    output rdata,
    output rd_valid
  );

endinterface

`default_nettype wire

//--- design/ram_pkg.sv
`default_nettype none

package ram_pkg;

  // Memory geometry.
  localparam int DEPTH  = 64;
  localparam int ADDR_W = 6;
  localparam int DATA_W = 16;

  // Holds a length of DEPTH words.
  localparam int LEN_W = 7;

  // Command opcodes.
  typedef enum logic [1:0] {
    OP_WRITE = 2'd0, // Store one word.
    OP_READ  = 2'd1, // Stream a range out.
    OP_FILL  = 2'd2, // One value over a range.
    OP_COPY  = 2'd3  // Range to range.
  } ram_op_e;

endpackage

`default_nettype wire
